//--- design/mul_pkg.sv
package mul_pkg;

    // widest datapath the unit is built for
    localparam int unsigned MAX_XLEN = 64;

    // ----------------------------------------------------------------------
    // operation codes
    // ----------------------------------------------------------------------
    // NOP stands for anything the issue logic sends that is not a multiply
    typedef enum logic [3:0] {
        NOP    = 4'd0,
        MUL    = 4'd1,
        MULH   = 4'd2,
        MULHU  = 4'd3,
        MULHSU = 4'd4,
        MULW   = 4'd5,
        CLMUL  = 4'd6,
        CLMULH = 4'd7,
        CLMULR = 4'd8
    } mul_op_e;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    // true for the eight multiply codes
    // MULW only exists on a 64 bit datapath
    function automatic logic is_mul_op(input mul_op_e op, input int unsigned xlen);
        logic hit;
        case (op)
            MUL, MULH, MULHU, MULHSU: hit = 1'b1;
            CLMUL, CLMULH, CLMULR:    hit = 1'b1;
            MULW:                     hit = (xlen == 64);
            default:                  hit = 1'b0;
        endcase
        return hit;
    endfunction

    // sign-extend a 32 bit word to the widest datapath
    // narrower users take the low XLEN bits
    function automatic logic [MAX_XLEN-1:0] sext32(input logic [31:0] word);
        return {{(MAX_XLEN-32){word[31]}}, word};
    endfunction

endpackage

//--- design/mul_stage_if.sv
`timescale 1ns/1ps

// prepared operands, operand stage -> product stage
interface mul_operand_if #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
);
    import mul_pkg::*;

    logic                     valid;
    logic [TRANS_ID_BITS-1:0] trans_id;
    mul_op_e                  op;
    // one extra bit carries the sign by operation
    logic [XLEN:0]            a_ext;
    logic [XLEN:0]            b_ext;
    // carry-less operands, already reversed for CLMULH / CLMULR
    logic [XLEN-1:0]          cl_a;
    logic [XLEN-1:0]          cl_b;

    modport producer (output valid, trans_id, op, a_ext, b_ext, cl_a, cl_b);
    modport consumer (input  valid, trans_id, op, a_ext, b_ext, cl_a, cl_b);
endinterface

// raw products, product stage -> result stage
interface mul_product_if #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
);
    import mul_pkg::*;

    logic                     valid;
    logic [TRANS_ID_BITS-1:0] trans_id;
    mul_op_e                  op;
    logic [2*XLEN-1:0]        prod;
    logic [XLEN-1:0]          clprod;

    modport producer (output valid, trans_id, op, prod, clprod);
    modport consumer (input  valid, trans_id, op, prod, clprod);
endinterface

//--- design/mul_operand_stage.sv
`timescale 1ns/1ps

module mul_operand_stage #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     valid_i,
    input  mul_pkg::mul_op_e         op_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  logic [XLEN-1:0]          operand_b_i,
    mul_operand_if.producer          out_o
);
    import mul_pkg::*;

    logic            mul_valid;
    logic            sign_a;
    logic            sign_b;
    logic            rev_mode;
    logic [XLEN-1:0] a_rev;
    logic [XLEN-1:0] b_rev;

    // ----------------------------------------------------------------------
    // filter and sign selection
    // ----------------------------------------------------------------------
    // non-multiply ops never enter the pipe
    assign mul_valid = valid_i && is_mul_op(op_i, XLEN);

    always_comb begin : p_sign_sel
        sign_a = 1'b0;
        sign_b = 1'b0;
        // signed x signed
        if (op_i == MULH) begin
            sign_a = 1'b1;
            sign_b = 1'b1;
        // signed x unsigned
        end else if (op_i == MULHSU) begin
            sign_a = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // carry-less operand reversal
    // ----------------------------------------------------------------------
    // high and reversed modes work on bit-reversed inputs
    assign rev_mode = (op_i == CLMULH) || (op_i == CLMULR);
    assign a_rev    = {<<{operand_a_i}};
    assign b_rev    = {<<{operand_b_i}};

    // ----------------------------------------------------------------------
    // stage register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_o.valid    <= 1'b0;
            out_o.trans_id <= '0;
            out_o.op       <= NOP;
            out_o.a_ext    <= '0;
            out_o.b_ext    <= '0;
            out_o.cl_a     <= '0;
            out_o.cl_b     <= '0;
        end else begin
            out_o.valid    <= mul_valid;
            out_o.trans_id <= trans_id_i;
            // rejected beats travel as NOP
            out_o.op       <= mul_valid ? op_i : NOP;
            out_o.a_ext    <= {operand_a_i[XLEN-1] & sign_a, operand_a_i};
            out_o.b_ext    <= {operand_b_i[XLEN-1] & sign_b, operand_b_i};
            out_o.cl_a     <= rev_mode ? a_rev : operand_a_i;
            out_o.cl_b     <= rev_mode ? b_rev : operand_b_i;
        end
    end

endmodule

//--- design/mul_product_stage.sv
`timescale 1ns/1ps

module mul_product_stage #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    mul_operand_if.consumer in_i,
    mul_product_if.producer out_o
);
    import mul_pkg::*;

    // full width of an (XLEN+1) x (XLEN+1) signed product
    localparam int unsigned FULL_W = 2 * XLEN + 2;

    logic signed [FULL_W-1:0] prod_full;
    logic [2*XLEN-1:0]        prod_d;
    logic [XLEN-1:0]          clmul_raw;
    logic [XLEN-1:0]          clmul_rev;
    logic [XLEN-1:0]          clprod_d;
    logic                     rev_mode;

    // ----------------------------------------------------------------------
    // integer product
    // ----------------------------------------------------------------------
    // both operands already carry their sign bit, so one signed
    // multiplier covers MUL, MULH, MULHU, MULHSU and MULW
    assign prod_full = $signed(in_i.a_ext) * $signed(in_i.b_ext);

    // top two bits are only sign copies
    assign prod_d = prod_full[2*XLEN-1:0];

    // ----------------------------------------------------------------------
    // carry-less product
    // ----------------------------------------------------------------------
    // xor of shifted copies of a, one per set bit of b
    // only the low word is ever needed
    always_comb begin : p_clmul
        clmul_raw = '0;
        for (int i = 0; i < XLEN; i++) begin
            if (in_i.cl_b[i]) begin
                clmul_raw = clmul_raw ^ (in_i.cl_a << i);
            end
        end
    end

    // reversed operands give a reversed upper half
    assign rev_mode  = (in_i.op == CLMULH) || (in_i.op == CLMULR);
    assign clmul_rev = {<<{clmul_raw}};

    // flip back so the result stage sees the CLMULR word
    assign clprod_d = rev_mode ? clmul_rev : clmul_raw;

    // ----------------------------------------------------------------------
    // stage register
    // ----------------------------------------------------------------------
    // single register after the multiplier
    // synthesis is expected to retime it into the array
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_o.valid    <= 1'b0;
            out_o.trans_id <= '0;
            out_o.op       <= NOP;
            out_o.prod     <= '0;
            out_o.clprod   <= '0;
        end else begin
            out_o.valid    <= in_i.valid;
            out_o.trans_id <= in_i.trans_id;
            out_o.op       <= in_i.op;
            // data follows valid unconditionally
            out_o.prod     <= prod_d;
            out_o.clprod   <= clprod_d;
        end
    end

endmodule

//--- design/mul_result_stage.sv
`timescale 1ns/1ps

module mul_result_stage #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    mul_product_if.consumer          in_i,
    output logic                     valid_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o,
    output logic [XLEN-1:0]          result_o
);
    import mul_pkg::*;

    logic [MAX_XLEN-1:0] mulw_word;
    logic [XLEN-1:0]     result_d;

    // low 32 bits sign-extended, cut to the datapath
    assign mulw_word = sext32(in_i.prod[31:0]);

    // ----------------------------------------------------------------------
    // result select
    // ----------------------------------------------------------------------
    always_comb begin : p_sel
        case (in_i.op)
            // upper word for all three high variants
            MULH, MULHU, MULHSU: result_d = in_i.prod[2*XLEN-1:XLEN];
            MULW:                result_d = mulw_word[XLEN-1:0];
            // clprod is the plain low word or the reversed-mode word
            CLMUL, CLMULR:       result_d = in_i.clprod;
            // high half is the reversed word moved down one place
            CLMULH:              result_d = in_i.clprod >> 1;
            // MUL, and NOP beats that nobody reads
            default:             result_d = in_i.prod[XLEN-1:0];
        endcase
    end

    // ----------------------------------------------------------------------
    // output register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o    <= 1'b0;
            trans_id_o <= '0;
            result_o   <= '0;
        end else begin
            valid_o    <= in_i.valid;
            trans_id_o <= in_i.trans_id;
            result_o   <= result_d;
        end
    end

endmodule

//--- design/mul_unit.sv
`timescale 1ns/1ps

module mul_unit #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     valid_i,
    input  mul_pkg::mul_op_e         op_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  logic [XLEN-1:0]          operand_b_i,
    output logic                     valid_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o,
    output logic [XLEN-1:0]          result_o
);

    // links between the three stages
    mul_operand_if #(.XLEN(XLEN), .TRANS_ID_BITS(TRANS_ID_BITS)) operand_bus ();
    mul_product_if #(.XLEN(XLEN), .TRANS_ID_BITS(TRANS_ID_BITS)) product_bus ();

    // ----------------------------------------------------------------------
    // stage 1: filter and prepare operands
    // ----------------------------------------------------------------------
    mul_operand_stage #(
        .XLEN          (XLEN),
        .TRANS_ID_BITS (TRANS_ID_BITS)
    ) i_operand_stage (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .trans_id_i  (trans_id_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .out_o       (operand_bus)
    );

    // stage 2: integer and carry-less products
    mul_product_stage #(
        .XLEN          (XLEN),
        .TRANS_ID_BITS (TRANS_ID_BITS)
    ) i_product_stage (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .in_i   (operand_bus),
        .out_o  (product_bus)
    );

    // stage 3: pick the destination word
    mul_result_stage #(
        .XLEN          (XLEN),
        .TRANS_ID_BITS (TRANS_ID_BITS)
    ) i_result_stage (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .in_i       (product_bus),
        .valid_o    (valid_o),
        .trans_id_o (trans_id_o),
        .result_o   (result_o)
    );

endmodule

//--- verification/mul_unit_assertions.sv
`timescale 1ns/1ps

module mul_unit_assertions #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input logic                     clk_i,
    input logic                     rst_ni,
    input logic                     valid_i,
    input mul_pkg::mul_op_e         op_i,
    input logic                     valid_o,
    input logic [TRANS_ID_BITS-1:0] trans_id_o,
    input logic [XLEN-1:0]          result_o
);
    import mul_pkg::*;

    logic accepted;

    // beats the operand stage lets into the pipe
    assign accepted = valid_i && is_mul_op(op_i, XLEN);

    // outputs held cleared under reset
    a_reset_idle: assert property (@(posedge clk_i)
        !rst_ni |-> (!valid_o && trans_id_o == '0 && result_o == '0))
        else $error("outputs not cleared while reset is low");

    // three cycle latency, no beat created or lost
    a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o == $past(accepted, 3))
        else $error("valid_o does not follow the accepted input by three cycles");

endmodule

bind mul_unit mul_unit_assertions #(
    .XLEN          (XLEN),
    .TRANS_ID_BITS (TRANS_ID_BITS)
) i_mul_unit_assertions (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .valid_o    (valid_o),
    .trans_id_o (trans_id_o),
    .result_o   (result_o)
);

//--- verification/tb_mul_unit.sv
`timescale 1ns/1ps

module tb_mul_unit;
    import mul_pkg::*;

    localparam int XLEN       = 64;
    localparam int ID_BITS    = 3;
    localparam int CLK_PERIOD = 100;
    // 8 ops x 16 corner pairs, 2 rejection rows, then random rows
    localparam int N_CORNER   = 8 * 16;
    localparam int N_ROWS     = N_CORNER + 2 + 64;

    typedef struct packed {
        logic            valid;
        mul_op_e         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] exp;
    } row_t;

    typedef struct packed {
        logic [ID_BITS-1:0] id;
        logic [XLEN-1:0]    result;
        logic [31:0]        due;
    } beat_t;

    logic               clk_i;
    logic               rst_ni;
    logic               valid_i;
    mul_op_e            op_i;
    logic [ID_BITS-1:0] trans_id_i;
    logic [XLEN-1:0]    operand_a_i;
    logic [XLEN-1:0]    operand_b_i;
    logic               valid_o;
    logic [ID_BITS-1:0] trans_id_o;
    logic [XLEN-1:0]    result_o;

    row_t        stim [N_ROWS];
    beat_t       exp_q [$];
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;
    int          value_errors = 0;
    int          proto_errors = 0;

    mul_unit #(
        .XLEN          (XLEN),
        .TRANS_ID_BITS (ID_BITS)
    ) i_mul_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .trans_id_i  (trans_id_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .valid_o     (valid_o),
        .trans_id_o  (trans_id_o),
        .result_o    (result_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // MULW only exists on a 64 bit datapath
    function automatic logic accepted_op(input mul_op_e op);
        return (op != NOP) && (op <= CLMULR) && !(op == MULW && XLEN != 64);
    endfunction

    function automatic logic [XLEN-1:0] model_result(input mul_op_e op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] sa;
        logic [2*XLEN-1:0] sb;
        logic [2*XLEN-1:0] za;
        logic [2*XLEN-1:0] zb;
        logic [2*XLEN-1:0] cl;
        logic [XLEN-1:0]   res;
        // 2*XLEN wide operands, product mod 2^(2*XLEN) is exact
        sa = {{XLEN{a[XLEN-1]}}, a};
        sb = {{XLEN{b[XLEN-1]}}, b};
        za = {{XLEN{1'b0}}, a};
        zb = {{XLEN{1'b0}}, b};
        cl = '0;
        for (int i = 0; i < XLEN; i++) begin
            if (b[i]) begin
                cl = cl ^ (za << i);
            end
        end
        case (op)
            MUL:     res = XLEN'(za * zb);
            MULH:    res = XLEN'((sa * sb) >> XLEN);
            MULHU:   res = XLEN'((za * zb) >> XLEN);
            MULHSU:  res = XLEN'((sa * zb) >> XLEN);
            // sign of the low word copied upward
            MULW: begin
                res[31:0]      = 32'(za * zb);
                res[XLEN-1:32] = {(XLEN-32){res[31]}};
            end
            CLMUL:   res = cl[XLEN-1:0];
            CLMULH:  res = cl[2*XLEN-1:XLEN];
            CLMULR:  res = cl[2*XLEN-2:XLEN-1];
            default: res = '0;
        endcase
        return res;
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_result(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_id(input string name, input logic [ID_BITS-1:0] got,
                            input logic [ID_BITS-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic fill_table();
        logic [XLEN-1:0] corner [4];
        mul_op_e         ops [8];
        logic [31:0]     w;
        int              n;
        corner[0] = '0;
        corner[1] = '1;
        corner[2] = {1'b1, {(XLEN-1){1'b0}}};
        corner[3] = XLEN'(1);
        ops = '{MUL, MULH, MULHU, MULHSU, MULW, CLMUL, CLMULH, CLMULR};
        n = 0;
        // every op against every corner pair
        for (int o = 0; o < 8; o++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    stim[n] = row_t'{1'b1, ops[o], corner[i], corner[j], '0};
                    n++;
                end
            end
        end
        // rejected: NOP issued, then a multiply without valid
        stim[n]     = row_t'{1'b1, NOP, '1, '1, '0};
        stim[n + 1] = row_t'{1'b0, MUL, '1, '1, '0};
        lcg_state = 32'h0f12_5f31;
        for (int r = n + 2; r < N_ROWS; r++) begin
            w = next_rand();
            // about one row in eight without valid, ops include NOP
            stim[r].valid = (w[31:29] != 3'd0);
            stim[r].op    = mul_op_e'(4'((w >> 16) % 9));
            stim[r].a     = {next_rand(), next_rand()};
            stim[r].b     = {next_rand(), next_rand()};
        end
        for (int r = 0; r < N_ROWS; r++) begin
            stim[r].exp = model_result(stim[r].op, stim[r].a, stim[r].b);
        end
    endtask

    // ----------------------------------------------------------------------
    // monitor, watchdog, main sequence
    // ----------------------------------------------------------------------
    always @(posedge clk_i) begin
        beat_t beat;
        if (rst_ni && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("%0t ns: output beat appeared with no operation pending", $time);
                proto_errors++;
            end else begin
                beat = exp_q.pop_front();
                check_id("trans_id_o", trans_id_o, beat.id);
                check_result("result_o", result_o, beat.result);
                if (32'(cycle_cnt) != beat.due) begin
                    $display("%0t ns: beat %0d left at the wrong cycle", $time, beat.id);
                    proto_errors++;
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (N_ROWS + 20));
        $display("watchdog expired before the run completed");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        valid_i     = 1'b0;
        op_i        = NOP;
        trans_id_i  = '0;
        operand_a_i = '0;
        operand_b_i = '0;
        fill_table();
        repeat (5) @(negedge clk_i);
        // still cleared from reset
        if (valid_o !== 1'b0) begin
            $display("valid_o is not low after reset");
            proto_errors++;
        end
        check_id("trans_id_o", trans_id_o, '0);
        check_result("result_o", result_o, '0);
        rst_ni = 1'b1;
        // rows back to back, one per cycle
        for (int i = 0; i < N_ROWS; i++) begin
            @(negedge clk_i);
            valid_i     = stim[i].valid;
            op_i        = stim[i].op;
            trans_id_i  = ID_BITS'(i);
            operand_a_i = stim[i].a;
            operand_b_i = stim[i].b;
            if (stim[i].valid && accepted_op(stim[i].op)) begin
                exp_q.push_back(beat_t'{ID_BITS'(i), stim[i].exp, 32'(cycle_cnt + 3)});
            end
        end
        @(negedge clk_i);
        valid_i = 1'b0;
        // latency is fixed at three, so this drains the pipe
        repeat (5) @(negedge clk_i);
        if (exp_q.size() != 0) begin
            $display("%0d expected beats never came out", exp_q.size());
            proto_errors++;
        end
        $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
design/mul_pkg.sv
design/mul_stage_if.sv
design/mul_operand_stage.sv
design/mul_product_stage.sv
design/mul_result_stage.sv
design/mul_unit.sv
verification/mul_unit_assertions.sv
verification/tb_mul_unit.sv

//--- Makefile
TOP = tb_mul_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f src.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
